//--- Makefile
SIM := obj_dir/VtbSdLogger
SRCS := $(wildcard rtl/*.sv verif/*.sv include/*.svh)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

$(SIM): tb.f $(SRCS)
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tbSdLogger -f tb.f -o VtbSdLogger

clean:
	rm -rf obj_dir

//--- include/sdlog_config.svh
`ifndef SDLOG_CONFIG_SVH
`define SDLOG_CONFIG_SVH

// uart timing, clock cycles per bit
`define SDLOG_CLKS_PER_BIT 16

// byte fifo, depth is 2**AW
`define SDLOG_FIFO_AW 11

// ------------------------------
// storage layout
// ------------------------------
`define SDLOG_SECTOR_BYTES 512
`define SDLOG_DATA_BASE 32'h0000_2000
`define SDLOG_DIR_SECTOR 32'h0000_1F00
`define SDLOG_START_CLUSTER 3

// directory rewrite period, in data sectors
`define SDLOG_FLUSH_SECTORS 4
// writer goes to full after this many data sectors
`define SDLOG_MAX_SECTORS 12

// 8.3 short name, padded, no dot
`define SDLOG_FILE_NAME "LOGDATA DAT"

`endif

//--- rtl/byteFifo.sv
`include "sdlog_config.svh"

module byteFifo (
  input  logic               clk,
  input  logic               rstn,
  input  logic               push,
  input  logic               pop,
  input  sdlogPkg::dataByte  din,
  output sdlogPkg::dataByte  head,
  output sdlogPkg::fifoCount count
);

  localparam int AddrW = `SDLOG_FIFO_AW;
  localparam int Depth = 1 << AddrW;

  sdlogPkg::dataByte mem [Depth];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic doPush;
  logic doPop;

  // full and empty requests are ignored
  assign doPush = push && (count != sdlogPkg::fifoCount'(Depth));
  assign doPop = pop && (count != '0);

  // show-ahead, head is the oldest byte
  assign head = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/dirEntryGen.sv
`include "sdlog_config.svh"

module dirEntryGen (
  input  sdlogPkg::byteIndex   index,
  input  sdlogPkg::sectorCount sectors,
  output sdlogPkg::dataByte    entryByte
);

  localparam logic [87:0] FileName = `SDLOG_FILE_NAME;
  localparam logic [31:0] StartCluster = 32'(`SDLOG_START_CLUSTER);
  // archive bit
  localparam logic [7:0] AttrByte = 8'h20;

  logic [31:0] fileLength;

  // whole sectors only
  assign fileLength = sectors << 9;

  // ------------------------------
  // short name entry, 32 bytes
  // ------------------------------
  always_comb
  begin
    entryByte = '0;
    if (index < 9'd11)
    begin
      // first character sits in the top byte of the string
      entryByte = FileName[8 * (10 - index) +: 8];
    end
    else
    begin
      case (index)
        9'd11: entryByte = AttrByte;
        // cluster high half
        9'd20: entryByte = StartCluster[23:16];
        9'd21: entryByte = StartCluster[31:24];
        // cluster low half
        9'd26: entryByte = StartCluster[7:0];
        9'd27: entryByte = StartCluster[15:8];
        // size, little endian
        9'd28: entryByte = fileLength[7:0];
        9'd29: entryByte = fileLength[15:8];
        9'd30: entryByte = fileLength[23:16];
        9'd31: entryByte = fileLength[31:24];
        default: entryByte = '0;
      endcase
    end
  end

endmodule

//--- rtl/logWriter.sv
`include "sdlog_config.svh"

module logWriter (
  input  logic                 clk,
  input  logic                 rstn,
  input  sdlogPkg::dataByte    fifoHead,
  input  sdlogPkg::fifoCount   fifoLevel,
  output logic                 fifoPop,
  input  sdlogPkg::sinkStatus  sink,
  output sdlogPkg::writeCmd    cmd,
  output sdlogPkg::writeData   wdata,
  output sdlogPkg::byteIndex   entryIndex,
  output sdlogPkg::sectorCount sectors,
  input  sdlogPkg::dataByte    entryByte,
  output sdlogPkg::logState    state
);

  localparam sdlogPkg::sectorAddr DataBase = `SDLOG_DATA_BASE;
  localparam sdlogPkg::sectorAddr DirSector = `SDLOG_DIR_SECTOR;
  localparam sdlogPkg::fifoCount SectorBytes = `SDLOG_SECTOR_BYTES;
  localparam sdlogPkg::sectorCount FlushSectors = `SDLOG_FLUSH_SECTORS;
  localparam sdlogPkg::sectorCount MaxSectors = `SDLOG_MAX_SECTORS;

  sdlogPkg::sectorCount sectorsNext;
  sdlogPkg::byteIndex byteCnt;
  // directory block started, waiting on its bytes
  logic dirActive;

  assign sectorsNext = sectors + 1'b1;
  assign entryIndex = byteCnt;

  // head is taken on the request, the fifo advances on the same edge
  assign fifoPop = (state == sdlogPkg::writeBlock) && sink.byteReq;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state <= sdlogPkg::waitData;
      sectors <= '0;
      byteCnt <= '0;
      dirActive <= 1'b0;
      cmd <= '0;
      wdata <= '0;
    end
    else
    begin
      // strobes are single cycle
      cmd.start <= 1'b0;
      wdata.valid <= 1'b0;

      case (state)
        // ------------------------------
        // data blocks
        // ------------------------------
        sdlogPkg::waitData:
        begin
          // a full sector must be buffered before starting
          if (fifoLevel >= SectorBytes && sink.ready)
          begin
            cmd.start <= 1'b1;
            cmd.sector <= DataBase + sectors;
            state <= sdlogPkg::writeBlock;
          end
        end

        sdlogPkg::writeBlock:
        begin
          if (sink.byteReq)
          begin
            wdata.valid <= 1'b1;
            wdata.data <= fifoHead;
          end
          if (sink.blockDone)
          begin
            sectors <= sectorsNext;
            // a flush boundary takes priority, full is checked after it
            if ((sectorsNext % FlushSectors) == '0)
            begin
              state <= sdlogPkg::dirUpdate;
            end
            else if (sectorsNext == MaxSectors)
            begin
              state <= sdlogPkg::logFull;
            end
            else
            begin
              state <= sdlogPkg::waitData;
            end
          end
        end

        // ------------------------------
        // directory rewrite
        // ------------------------------
        sdlogPkg::dirUpdate:
        begin
          if (!dirActive)
          begin
            if (sink.ready)
            begin
              cmd.start <= 1'b1;
              cmd.sector <= DirSector;
              dirActive <= 1'b1;
              byteCnt <= '0;
            end
          end
          else
          begin
            if (sink.byteReq)
            begin
              wdata.valid <= 1'b1;
              wdata.data <= entryByte;
              byteCnt <= byteCnt + 1'b1;
            end
            if (sink.blockDone)
            begin
              dirActive <= 1'b0;
              state <= (sectors == MaxSectors) ? sdlogPkg::logFull : sdlogPkg::waitData;
            end
          end
        end

        // terminal, only reset leaves it
        sdlogPkg::logFull:
        begin
          state <= sdlogPkg::logFull;
        end

        default:
        begin
          state <= sdlogPkg::waitData;
        end
      endcase
    end
  end

endmodule

//--- rtl/sdLogger.sv
module sdLogger (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rx,
  input  sdlogPkg::sinkStatus sink,
  output sdlogPkg::writeCmd   cmd,
  output sdlogPkg::writeData  wdata,
  output sdlogPkg::logState   state
);

  sdlogPkg::dataByte rxByte;
  logic rxStrobe;

  sdlogPkg::dataByte fifoHead;
  sdlogPkg::fifoCount fifoLevel;
  logic fifoPop;

  sdlogPkg::byteIndex entryIndex;
  sdlogPkg::sectorCount sectors;
  sdlogPkg::dataByte entryByte;

  // ------------------------------
  // receive path
  // ------------------------------
  uartRx rxUnit (
    .clk      (clk),
    .rstn     (rstn),
    .rx       (rx),
    .rxByte   (rxByte),
    .rxStrobe (rxStrobe)
  );

  // bytes arriving while full are lost
  byteFifo fifo (
    .clk   (clk),
    .rstn  (rstn),
    .push  (rxStrobe),
    .pop   (fifoPop),
    .din   (rxByte),
    .head  (fifoHead),
    .count (fifoLevel)
  );

  // ------------------------------
  // write path
  // ------------------------------
  dirEntryGen entryGen (
    .index     (entryIndex),
    .sectors   (sectors),
    .entryByte (entryByte)
  );

  logWriter writer (
    .clk        (clk),
    .rstn       (rstn),
    .fifoHead   (fifoHead),
    .fifoLevel  (fifoLevel),
    .fifoPop    (fifoPop),
    .sink       (sink),
    .cmd        (cmd),
    .wdata      (wdata),
    .entryIndex (entryIndex),
    .sectors    (sectors),
    .entryByte  (entryByte),
    .state      (state)
  );

endmodule

//--- rtl/sdlogPkg.sv
`include "sdlog_config.svh"

package sdlogPkg;

  typedef logic [7:0] dataByte;
  typedef logic [31:0] sectorAddr;
  typedef logic [8:0] byteIndex;
  typedef logic [`SDLOG_FIFO_AW:0] fifoCount;
  typedef logic [31:0] sectorCount;

  // writer to block sink
  typedef struct packed {
    logic start;
    sectorAddr sector;
  } writeCmd;

  typedef struct packed {
    logic valid;
    dataByte data;
  } writeData;

  // block sink to writer
  typedef struct packed {
    logic ready;
    logic byteReq;
    logic blockDone;
  } sinkStatus;

  typedef enum logic [1:0] {waitData, writeBlock, dirUpdate, logFull} logState;

endpackage

//--- rtl/uartRx.sv
`include "sdlog_config.svh"

module uartRx (
  input  logic              clk,
  input  logic              rstn,
  input  logic              rx,
  output sdlogPkg::dataByte rxByte,
  output logic              rxStrobe
);

  localparam int ClksPerBit = `SDLOG_CLKS_PER_BIT;
  localparam int CntW = $clog2(ClksPerBit);

  logic [1:0] rxSync;
  logic rxBit;
  logic busy;
  logic [CntW-1:0] clkCnt;
  logic [3:0] bitCnt;
  logic sampleNow;
  sdlogPkg::dataByte shiftReg;

  assign rxBit = rxSync[1];
  assign sampleNow = busy && (clkCnt == '0);
  // shifter holds the byte until the next frame starts shifting
  assign rxByte = shiftReg;

  // line idles high
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rxSync <= 2'b11;
    end
    else
    begin
      rxSync <= {rxSync[0], rx};
    end
  end

  // ------------------------------
  // bit timing
  // ------------------------------
  // bitCnt 0 is the start bit, 1..8 data, 9 stop
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      busy <= 1'b0;
      clkCnt <= '0;
      bitCnt <= '0;
      rxStrobe <= 1'b0;
    end
    else
    begin
      rxStrobe <= 1'b0;
      if (!busy)
      begin
        if (!rxBit)
        begin
          busy <= 1'b1;
          // first sample lands mid start bit
          clkCnt <= CntW'(ClksPerBit / 2 - 1);
          bitCnt <= '0;
        end
      end
      else if (!sampleNow)
      begin
        clkCnt <= clkCnt - 1'b1;
      end
      else
      begin
        clkCnt <= CntW'(ClksPerBit - 1);
        bitCnt <= bitCnt + 1'b1;
        if (bitCnt == 4'd0 && rxBit)
        begin
          // glitch, not a real start bit
          busy <= 1'b0;
        end
        else if (bitCnt == 4'd9)
        begin
          busy <= 1'b0;
          // framing error drops the byte
          rxStrobe <= rxBit;
        end
      end
    end
  end

  // lsb first
  always_ff @(posedge clk)
  begin
    if (sampleNow && bitCnt >= 4'd1 && bitCnt <= 4'd8)
    begin
      shiftReg <= {rxBit, shiftReg[7:1]};
    end
  end

endmodule

//--- tb.f
+incdir+include
rtl/sdlogPkg.sv
rtl/uartRx.sv
rtl/byteFifo.sv
rtl/dirEntryGen.sv
rtl/logWriter.sv
rtl/sdLogger.sv
verif/tbSdLogger.sv

//--- verif/tbSdLogger.sv
`include "sdlog_config.svh"

module tbSdLogger;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TotalBytes = `SDLOG_MAX_SECTORS * `SDLOG_SECTOR_BYTES;
  localparam int unsigned ByteNs = 10 * `SDLOG_CLKS_PER_BIT * 8;
  // twice the uart time of the whole log, plus margin for block writes
  localparam int unsigned WatchdogNs = 2 * TotalBytes * ByteNs + 2_000_000;
  localparam sdlogPkg::sectorAddr DataBase = `SDLOG_DATA_BASE;
  localparam sdlogPkg::sectorAddr DirSector = `SDLOG_DIR_SECTOR;

  logic clk;
  logic rstn;
  logic rx;
  sdlogPkg::sinkStatus sink;
  sdlogPkg::writeCmd cmd;
  sdlogPkg::writeData wdata;
  sdlogPkg::logState state;

  // reference model
  sdlogPkg::dataByte expBytes[$];
  sdlogPkg::sectorCount modelSectors;
  logic dirDue;
  sdlogPkg::sectorAddr lastSector;
  int startCount = 0;
  int dataBlocks = 0;
  int dirBlocks = 0;
  int sentBytes = 0;
  logic holdReady;

  int errors = 0;
  int errBase = 0;
  int testNum = 0;
  int passCount = 0;
  int failCount = 0;

  sdLogger dut_i (
    .clk   (clk),
    .rstn  (rstn),
    .rx    (rx),
    .sink  (sink),
    .cmd   (cmd),
    .wdata (wdata),
    .state (state)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic checkByte(input sdlogPkg::dataByte got, input sdlogPkg::dataByte exp,
                           input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkSector(input sdlogPkg::sectorAddr got, input sdlogPkg::sectorAddr exp,
                             input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkState(input sdlogPkg::logState got, input sdlogPkg::logState exp,
                            input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  // expected directory byte, from the 8.3 short entry layout
  function automatic sdlogPkg::dataByte entryRef(input int idx, input sdlogPkg::sectorCount secs);
    string name;
    logic [31:0] cluster;
    logic [31:0] length;
    name = `SDLOG_FILE_NAME;
    cluster = `SDLOG_START_CLUSTER;
    length = secs * `SDLOG_SECTOR_BYTES;
    if (idx < 11)
      return name.getc(idx);
    case (idx)
      11: return 8'h20;
      20: return cluster[23:16];
      21: return cluster[31:24];
      26: return cluster[7:0];
      27: return cluster[15:8];
      28, 29, 30, 31: return length[8 * (idx - 28) +: 8];
      default: return 8'h00;
    endcase
  endfunction

  // 8n1 frame, lsb first
  task automatic sendByte(input sdlogPkg::dataByte b);
    expBytes.push_back(b);
    sentBytes++;
    @(negedge clk);
    rx = 1'b0;
    repeat (`SDLOG_CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      rx = b[i];
      repeat (`SDLOG_CLKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;
    repeat (`SDLOG_CLKS_PER_BIT) @(negedge clk);
  endtask

  // ------------------------------
  // block sink model
  // ------------------------------
  task automatic serveBlock(input logic isDir);
    int gap;
    sdlogPkg::dataByte expected;
    for (int i = 0; i < `SDLOG_SECTOR_BYTES; i++)
    begin
      gap = 2 + int'($urandom % 5);
      repeat (gap)
      begin
        @(negedge clk);
        if (wdata.valid)
        begin
          $display("%0t: byte strobe arrived without a byte request", $time);
          errors++;
        end
      end
      sink.byteReq = 1'b1;
      @(negedge clk);
      sink.byteReq = 1'b0;
      if (!wdata.valid)
      begin
        $display("%0t: no byte strobe in the cycle after byte request %0d", $time, i);
        errors++;
      end
      else if (isDir)
      begin
        checkByte(wdata.data, entryRef(i, modelSectors), $sformatf("directory byte %0d", i));
      end
      else if (expBytes.size() == 0)
      begin
        $display("%0t: writer sent a data byte that was never received", $time);
        errors++;
      end
      else
      begin
        expected = expBytes.pop_front();
        checkByte(wdata.data, expected, $sformatf("data byte %0d", i));
      end
    end
    @(negedge clk);
    sink.blockDone = 1'b1;
    @(negedge clk);
    sink.blockDone = 1'b0;
  endtask

  initial
  begin : sinkModel
    int idle;
    logic isDir;
    sink = '0;
    modelSectors = '0;
    dirDue = 1'b0;
    lastSector = '0;
    idle = 0;
    forever
    begin
      @(negedge clk);
      if (cmd.start)
      begin
        if (!sink.ready)
        begin
          $display("%0t: block started while sink.ready was low", $time);
          errors++;
        end
        isDir = dirDue;
        lastSector = cmd.sector;
        startCount++;
        checkSector(cmd.sector, isDir ? DirSector : DataBase + modelSectors, "block sector");
        serveBlock(isDir);
        if (isDir)
        begin
          dirDue = 1'b0;
          dirBlocks++;
        end
        else
        begin
          modelSectors++;
          dataBlocks++;
          if ((modelSectors % `SDLOG_FLUSH_SECTORS) == 0)
            dirDue = 1'b1;
        end
        // random busy stretch after each block, starting right away
        idle = int'($urandom % 16);
        sink.ready = !(holdReady || idle > 0);
      end
      else
      begin
        if (wdata.valid)
        begin
          $display("%0t: byte strobe arrived outside a block", $time);
          errors++;
        end
        sink.ready = !(holdReady || idle > 0);
        if (idle > 0)
          idle--;
      end
    end
  end

  task automatic waitBlocks(input int nData, input int nDir);
    int n;
    n = 0;
    while ((dataBlocks < nData || dirBlocks < nDir) && n < 40000)
    begin
      @(posedge clk);
      n++;
    end
    if (dataBlocks < nData || dirBlocks < nDir)
    begin
      $display("%0t: timed out waiting for %0d data and %0d directory blocks",
               $time, nData, nDir);
      errors++;
    end
  endtask

  task automatic endTest(input string name);
    testNum++;
    if (errors == errBase)
    begin
      passCount++;
      $display("test %0d %s: pass", testNum, name);
    end
    else
    begin
      failCount++;
      $display("test %0d %s: fail, %0d errors", testNum, name, errors - errBase);
    end
    errBase = errors;
  endtask

  initial
  begin : watchdog
    #(WatchdogNs);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin : mainSeq
    int startsBefore;
    void'($urandom(32'h9a1d));
    rx = 1'b1;
    rstn = 1'b0;
    holdReady = 1'b0;
    repeat (4) @(negedge clk);
    rstn = 1'b1;

    repeat (100) @(posedge clk);
    if (startCount != 0)
    begin
      $display("%0t: block started with no input", $time);
      errors++;
    end
    @(negedge clk);
    checkState(state, sdlogPkg::waitData, "state after reset");
    endTest("idle after reset");

    for (int i = 0; i < 511; i++)
      sendByte(sdlogPkg::dataByte'($urandom));
    repeat (4 * `SDLOG_CLKS_PER_BIT) @(posedge clk);
    if (startCount != 0)
    begin
      $display("%0t: block started with only 511 bytes buffered", $time);
      errors++;
    end
    sendByte(sdlogPkg::dataByte'($urandom));
    waitBlocks(1, 0);
    checkSector(lastSector, DataBase, "first data sector");
    endTest("first block at 512 bytes");

    for (int i = 0; i < 3 * `SDLOG_SECTOR_BYTES; i++)
      sendByte(sdlogPkg::dataByte'($urandom));
    waitBlocks(4, 0);
    endTest("data blocks in order");

    waitBlocks(4, 1);
    @(negedge clk);
    checkState(state, sdlogPkg::waitData, "state after directory update");
    endTest("directory update");

    // sink held busy across a full sector of input
    @(posedge clk);
    holdReady = 1'b1;
    repeat (4) @(posedge clk);
    startsBefore = startCount;
    for (int i = 0; i < 600; i++)
      sendByte(sdlogPkg::dataByte'($urandom));
    repeat (4 * `SDLOG_CLKS_PER_BIT) @(posedge clk);
    if (startCount != startsBefore)
    begin
      $display("%0t: block started while sink.ready was held low", $time);
      errors++;
    end
    @(negedge clk);
    checkState(state, sdlogPkg::waitData, "state while sink not ready");
    @(posedge clk);
    holdReady = 1'b0;
    waitBlocks(5, 1);
    endTest("back-pressure");

    while (sentBytes < TotalBytes)
      sendByte(sdlogPkg::dataByte'($urandom));
    waitBlocks(`SDLOG_MAX_SECTORS, `SDLOG_MAX_SECTORS / `SDLOG_FLUSH_SECTORS);
    repeat (4) @(posedge clk);
    @(negedge clk);
    checkState(state, sdlogPkg::logFull, "state at sector limit");
    repeat (4) @(posedge clk);
    startsBefore = startCount;
    // a whole sector, enough to start a block below the limit
    for (int i = 0; i < `SDLOG_SECTOR_BYTES; i++)
      sendByte(sdlogPkg::dataByte'($urandom));
    repeat (4 * `SDLOG_CLKS_PER_BIT) @(posedge clk);
    if (startCount != startsBefore)
    begin
      $display("%0t: block started after the sector limit", $time);
      errors++;
    end
    @(negedge clk);
    checkState(state, sdlogPkg::logFull, "state after extra input");
    endTest("sector limit");

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             testNum, passCount, failCount, errors);
    if (errors == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
